//--- compile.f
ghash_pkg.sv
ghash_key_table.sv
ghash_group_scheduler.sv
ghash_lane.sv
ghash_fold_reduce.sv
ghash_core.sv
ghash_props.sv
tb_ghash.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ghash -f compile.f

# Assertion errors are counted by the testbench instead of stopping the run
./obj_dir/Vtb_ghash +verilator+error+limit+100 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- tb_ghash.sv
module tb_ghash;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BB         = ghash_pkg::BLOCK_BITS;
    localparam int WAIT_LIMIT = 2000;
    // R = 11100001 || 0^120 from the GCM specification
    localparam ghash_pkg::block_t R_CONST = {8'he1, 120'd0};

    logic                clock = 1'b0;
    logic                reset = 1'b1;
    logic                key_load;
    ghash_pkg::block_t   hash_key;
    logic                valid;
    ghash_pkg::group_t   group;
    logic                sop;
    logic                eop;
    logic                credit;
    logic                key_ready;
    logic                tag_valid;
    ghash_pkg::block_t   tag;

    int                  credits;
    int                  credit_pulses;
    int                  tests_run;
    int                  tests_failed;
    logic [31:0]         lcg_state = 32'd33;
    ghash_pkg::group_t   msg_groups [$];
    ghash_pkg::block_t   expected_q [$];
    string               name_q [$];
    ghash_pkg::block_t   tag_q [$];
    ghash_pkg::block_t   last_tag;

    ghash_core DUT (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_key_load  (key_load),
        .i_hash_key  (hash_key),
        .i_valid     (valid),
        .i_group     (group),
        .i_sop       (sop),
        .i_eop       (eop),
        .o_credit    (credit),
        .o_key_ready (key_ready),
        .o_tag_valid (tag_valid),
        .o_tag       (tag)
    );

    always #4 clock = ~clock;

    // Outputs are settled mid-cycle
    always @(negedge clock) begin
        if (!reset && credit) begin
            credits++;
            credit_pulses++;
        end
        if (tag_valid) begin
            tag_q.push_back(tag);
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic ghash_pkg::block_t random_block();
        ghash_pkg::block_t b;
        for (int i = 0; i < BB / 32; i++) begin
            b[32*i +: 32] = next_random();
        end
        return b;
    endfunction

    // Bit-serial multiply with bit 127 as the x^0 coefficient
    function automatic ghash_pkg::block_t gf_mult_serial(input ghash_pkg::block_t x,
                                                         input ghash_pkg::block_t y);
        ghash_pkg::block_t z;
        ghash_pkg::block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < BB; i++) begin
            if (x[BB-1-i]) begin
                z = z ^ v;
            end
            v = v[0] ? ((v >> 1) ^ R_CONST) : (v >> 1);
        end
        return z;
    endfunction

    // Sequential GHASH over every block of the message
    function automatic ghash_pkg::block_t model_tag(input ghash_pkg::block_t key);
        ghash_pkg::block_t y;
        ghash_pkg::group_t grp;
        y = '0;
        for (int g = 0; g < msg_groups.size(); g++) begin
            grp = msg_groups[g];
            for (int k = 0; k < ghash_pkg::N_LANES; k++) begin
                y = gf_mult_serial(y ^ grp[k*BB +: BB], key);
            end
        end
        return y;
    endfunction

    task automatic abort_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic compare_block(input string name, input ghash_pkg::block_t expected,
                                 input ghash_pkg::block_t actual);
        tests_run++;
        if (expected === actual) begin
            $display("pass %s tag %h", name, actual);
        end else begin
            tests_failed++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_count(input string name, input int expected, input int actual);
        tests_run++;
        if (expected == actual) begin
            $display("pass %s count %0d", name, actual);
        end else begin
            tests_failed++;
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_condition(input string name, input bit ok, input string text);
        tests_run++;
        if (ok) begin
            $display("pass %s", name);
        end else begin
            tests_failed++;
            $display("%s: %s", name, text);
        end
    endtask

    task automatic hold_reset();
        reset    <= 1'b1;
        valid    <= 1'b0;
        sop      <= 1'b0;
        eop      <= 1'b0;
        key_load <= 1'b0;
        repeat (3) @(posedge clock);
        reset   <= 1'b0;
        credits = ghash_pkg::FIFO_DEPTH;
    endtask

    task automatic load_key(input ghash_pkg::block_t key);
        int cycles;
        @(posedge clock);
        key_load <= 1'b1;
        hash_key <= key;
        @(posedge clock);
        key_load <= 1'b0;
        cycles = 0;
        @(negedge clock);
        while (!key_ready) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_timeout("o_key_ready after a key load");
            end
            @(negedge clock);
        end
    endtask

    task automatic build_message(input int n_groups, input bit zero_data);
        ghash_pkg::group_t grp;
        msg_groups.delete();
        for (int g = 0; g < n_groups; g++) begin
            for (int k = 0; k < ghash_pkg::N_LANES; k++) begin
                grp[k*BB +: BB] = zero_data ? '0 : random_block();
            end
            msg_groups.push_back(grp);
        end
    endtask

    task automatic expect_tag(input string name, input ghash_pkg::block_t value);
        name_q.push_back(name);
        expected_q.push_back(value);
    endtask

    // Sends the first n_send groups, each on a credit
    task automatic send_groups(input int n_send);
        int g;
        int idle;
        g    = 0;
        idle = 0;
        while (g < n_send) begin
            @(posedge clock);
            if (credits > 0) begin
                valid <= 1'b1;
                group <= msg_groups[g];
                sop   <= (g == 0);
                eop   <= (g == msg_groups.size() - 1);
                credits--;
                g++;
                idle = 0;
            end else begin
                valid <= 1'b0;
                idle++;
                if (idle > WAIT_LIMIT) begin
                    abort_timeout("a returned credit");
                end
            end
        end
    endtask

    task automatic release_inputs();
        @(posedge clock);
        valid <= 1'b0;
        sop   <= 1'b0;
        eop   <= 1'b0;
    endtask

    task automatic drain_tags();
        int cycles;
        ghash_pkg::block_t actual;
        cycles = 0;
        while (tag_q.size() < expected_q.size()) begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_timeout("o_tag_valid");
            end
        end
        while (expected_q.size() > 0) begin
            actual   = tag_q.pop_front();
            last_tag = actual;
            compare_block(name_q.pop_front(), expected_q.pop_front(), actual);
        end
    endtask

    initial begin
        ghash_pkg::block_t key_a;
        ghash_pkg::block_t key_b;
        ghash_pkg::block_t old_tag;
        int n;
        int pulses_before;
        key_load      = 1'b0;
        hash_key      = '0;
        valid         = 1'b0;
        group         = '0;
        sop           = 1'b0;
        eop           = 1'b0;
        credits       = ghash_pkg::FIFO_DEPTH;
        credit_pulses = 0;
        tests_run     = 0;
        tests_failed  = 0;
        hold_reset();

        // One group with sop and eop together
        key_a = random_block();
        load_key(key_a);
        build_message(1, 1'b0);
        expect_tag("single_group", model_tag(key_a));
        send_groups(1);
        release_inputs();
        drain_tags();

        // Back to back random messages
        for (int m = 0; m < 10; m++) begin
            n = 1 + int'(next_random() % 32'd9);
            build_message(n, 1'b0);
            expect_tag($sformatf("random_msg_%0d", m), model_tag(key_a));
            send_groups(n);
        end
        release_inputs();
        drain_tags();

        // Burst on every credit, then paced by returns
        n = 3 * ghash_pkg::FIFO_DEPTH;
        build_message(n, 1'b0);
        pulses_before = credit_pulses;
        expect_tag("credit_burst", model_tag(key_a));
        send_groups(n);
        release_inputs();
        drain_tags();
        compare_count("credit_pulses", n, credit_pulses - pulses_before);

        // Same data under two keys
        build_message(3, 1'b0);
        expect_tag("old_key", model_tag(key_a));
        send_groups(3);
        release_inputs();
        drain_tags();
        old_tag = last_tag;
        key_b = random_block();
        load_key(key_b);
        expect_tag("new_key", model_tag(key_b));
        send_groups(3);
        release_inputs();
        drain_tags();
        check_condition("new_key_differs", last_tag !== old_tag,
                        "the tag under the new key equals the tag under the old key");

        build_message(4, 1'b1);
        expect_tag("zero_message", '0);
        send_groups(4);
        release_inputs();
        drain_tags();

        // Reset while the eop group still waits in the buffer
        build_message(6, 1'b0);
        send_groups(6);
        release_inputs();
        hold_reset();
        repeat (20) @(negedge clock);
        check_condition("reset_no_tag", tag_q.size() == 0,
                        "a tag appeared after a reset in the middle of a message");
        load_key(key_b);
        build_message(ghash_pkg::FIFO_DEPTH + 2, 1'b0);
        expect_tag("after_reset", model_tag(key_b));
        send_groups(ghash_pkg::FIFO_DEPTH + 2);
        release_inputs();
        drain_tags();

        $display("tests run %0d, failed %0d, assertion errors %0d",
                 tests_run, tests_failed, DUT.u_props.error_count);
        if (tests_failed == 0 && DUT.u_props.error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- ghash_props.sv
module ghash_props (
    input  logic    i_clock,
    input  logic    i_reset,
    input  logic    i_valid,
    input  logic    i_credit,
    input  logic    i_tag_valid,
    input  logic    i_key_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Groups accepted on i_valid and not yet returned as credits
    int held_count;
    int error_count = 0;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            held_count <= 0;
        end else begin
            held_count <= held_count + (i_valid ? 1 : 0) - (i_credit ? 1 : 0);
        end
    end

    // First reset cycle may still show state from before the reset
    reset_quiet: assert property (@(posedge i_clock) i_reset |=> (!i_credit && !i_tag_valid))
        else begin
            error_count++;
            $error("credit or tag pulse during reset or in the first cycle after it");
        end

    tag_single: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tag_valid |=> !i_tag_valid)
        else begin
            error_count++;
            $error("tag valid held for two consecutive cycles");
        end

    credit_bound: assert property (@(posedge i_clock) disable iff (i_reset)
        held_count <= ghash_pkg::FIFO_DEPTH)
        else begin
            error_count++;
            $error("more groups held than the buffer has room for: %0d", held_count);
        end

    tag_keyed: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tag_valid |-> i_key_ready)
        else begin
            error_count++;
            $error("tag produced while the key table is not ready");
        end

endmodule

bind ghash_core ghash_props u_props (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_credit    (o_credit),
    .i_tag_valid (o_tag_valid),
    .i_key_ready (o_key_ready)
);

//--- ghash_core.sv
module ghash_core (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_key_load,
    input  ghash_pkg::block_t   i_hash_key,
    input  logic                i_valid,
    input  ghash_pkg::group_t   i_group,
    input  logic                i_sop,
    input  logic                i_eop,
    output logic                o_credit,
    output logic                o_key_ready,
    output logic                o_tag_valid,
    output ghash_pkg::block_t   o_tag
);

    ghash_pkg::block_t   [ghash_pkg::N_LANES-1:0]  key_powers;
    ghash_pkg::block_t   [ghash_pkg::N_LANES-1:0]  lane_x;
    ghash_pkg::block_t   [ghash_pkg::N_LANES-1:0]  lane_h;
    ghash_pkg::product_t [ghash_pkg::N_LANES-1:0]  products;
    logic                [ghash_pkg::N_LANES-1:0]  lane_valid;
    logic                                          issue_valid;
    logic                                          issue_eop;
    logic                                          prod_valid;
    ghash_pkg::block_t                             hash_y;
    logic                                          y_valid;

    ghash_key_table u_key_table (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_key_load   (i_key_load),
        .i_hash_key   (i_hash_key),
        .o_key_powers (key_powers),
        .o_key_ready  (o_key_ready)
    );

    ghash_group_scheduler u_scheduler (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_group       (i_group),
        .i_sop         (i_sop),
        .i_eop         (i_eop),
        .i_key_powers  (key_powers),
        .i_key_ready   (o_key_ready),
        .i_hash_y      (hash_y),
        .i_y_valid     (y_valid),
        .o_credit      (o_credit),
        .o_issue_valid (issue_valid),
        .o_issue_eop   (issue_eop),
        .o_lane_x      (lane_x),
        .o_lane_h      (lane_h)
    );

    for (genvar k = 0; k < ghash_pkg::N_LANES; k++) begin : g_lane
        ghash_lane u_lane (
            .i_clock   (i_clock),
            .i_reset   (i_reset),
            .i_valid   (issue_valid),
            .i_x       (lane_x[k]),
            .i_h       (lane_h[k]),
            .o_valid   (lane_valid[k]),
            .o_product (products[k])
        );
    end

    // All lanes run in lockstep
    assign prod_valid = &lane_valid;

    ghash_fold_reduce u_fold_reduce (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_valid     (prod_valid),
        .i_eop       (issue_eop),
        .i_products  (products),
        .o_y_valid   (y_valid),
        .o_hash_y    (hash_y),
        .o_tag_valid (o_tag_valid),
        .o_tag       (o_tag)
    );

endmodule

//--- ghash_fold_reduce.sv
module ghash_fold_reduce (
    input  logic                                           i_clock,
    input  logic                                           i_reset,
    input  logic                                           i_valid,
    input  logic                                           i_eop,
    input  ghash_pkg::product_t [ghash_pkg::N_LANES-1:0]   i_products,
    output logic                                           o_y_valid,
    output ghash_pkg::block_t                              o_hash_y,
    output logic                                           o_tag_valid,
    output ghash_pkg::block_t                              o_tag
);

    ghash_pkg::product_t    folded;
    ghash_pkg::block_t      reduced;
    // Eop mark aligned with the lane products
    logic                   eop_d;

    // Field addition of all lane products before one reduction
    always_comb begin
        folded = '0;
        for (int k = 0; k < ghash_pkg::N_LANES; k++) begin
            folded = folded ^ i_products[k];
        end
    end

    assign reduced = ghash_pkg::gf_reduce(folded);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            eop_d       <= 1'b0;
            o_y_valid   <= 1'b0;
            o_tag_valid <= 1'b0;
        end else begin
            eop_d       <= i_eop;
            o_y_valid   <= i_valid;
            o_tag_valid <= i_valid && eop_d;
        end
    end

    // Running hash, and the tag held until the next message ends
    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_hash_y <= reduced;
            if (eop_d) begin
                o_tag <= reduced;
            end
        end
    end

endmodule

//--- ghash_lane.sv
module ghash_lane (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_valid,
    input  ghash_pkg::block_t   i_x,
    input  ghash_pkg::block_t   i_h,
    output logic                o_valid,
    output ghash_pkg::product_t o_product
);

    // Valid tracks the product register one cycle behind the operands
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Reduction happens once per group in the fold stage
    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_product <= ghash_pkg::clmul(i_x, i_h);
        end
    end

endmodule

//--- ghash_group_scheduler.sv
module ghash_group_scheduler (
    input  logic                                        i_clock,
    input  logic                                        i_reset,
    input  logic                                        i_valid,
    input  ghash_pkg::group_t                           i_group,
    input  logic                                        i_sop,
    input  logic                                        i_eop,
    input  ghash_pkg::block_t [ghash_pkg::N_LANES-1:0]  i_key_powers,
    input  logic                                        i_key_ready,
    input  ghash_pkg::block_t                           i_hash_y,
    input  logic                                        i_y_valid,
    output logic                                        o_credit,
    output logic                                        o_issue_valid,
    output logic                                        o_issue_eop,
    output ghash_pkg::block_t [ghash_pkg::N_LANES-1:0]  o_lane_x,
    output ghash_pkg::block_t [ghash_pkg::N_LANES-1:0]  o_lane_h
);

    ghash_pkg::group_t                          buf_group [ghash_pkg::FIFO_DEPTH];
    logic                                       buf_sop   [ghash_pkg::FIFO_DEPTH];
    logic                                       buf_eop   [ghash_pkg::FIFO_DEPTH];
    logic [$clog2(ghash_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(ghash_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(ghash_pkg::FIFO_DEPTH+1)-1:0] fill;
    logic                                       outstanding;
    logic                                       push;
    logic                                       pop;
    ghash_pkg::group_t                          head_group;
    ghash_pkg::block_t                          chain;

    // A full buffer only sees i_valid on a credit error, so drop it
    assign push = i_valid && (fill != ghash_pkg::FIFO_DEPTH);

    // Next group may go out in the same cycle the previous hash returns
    assign pop = (fill != 0) && i_key_ready && (!outstanding || i_y_valid);

    assign o_credit   = pop;
    assign head_group = buf_group[rd_ptr];

    // Start of a message chains from zero instead of the running hash
    assign chain = buf_sop[rd_ptr] ? '0 : i_hash_y;

    always_ff @(posedge i_clock) begin
        if (push) begin
            buf_group[wr_ptr] <= i_group;
            buf_sop[wr_ptr]   <= i_sop;
            buf_eop[wr_ptr]   <= i_eop;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ghash_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ghash_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Issue and outstanding tracking
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            outstanding   <= 1'b0;
            o_issue_valid <= 1'b0;
            o_issue_eop   <= 1'b0;
        end else begin
            o_issue_valid <= pop;
            if (pop) begin
                outstanding <= 1'b1;
                o_issue_eop <= buf_eop[rd_ptr];
            end else if (i_y_valid) begin
                outstanding <= 1'b0;
            end
        end
    end

    // Lane k multiplies by H^(N_LANES-k)
    always_ff @(posedge i_clock) begin
        if (pop) begin
            for (int k = 0; k < ghash_pkg::N_LANES; k++) begin
                if (k == 0) begin
                    o_lane_x[k] <= head_group[0 +: ghash_pkg::BLOCK_BITS] ^ chain;
                end else begin
                    o_lane_x[k] <= head_group[k*ghash_pkg::BLOCK_BITS +: ghash_pkg::BLOCK_BITS];
                end
                o_lane_h[k] <= i_key_powers[ghash_pkg::N_LANES-1-k];
            end
        end
    end

endmodule

//--- ghash_key_table.sv
module ghash_key_table (
    input  logic                                        i_clock,
    input  logic                                        i_reset,
    input  logic                                        i_key_load,
    input  ghash_pkg::block_t                           i_hash_key,
    output ghash_pkg::block_t [ghash_pkg::N_LANES-1:0]  o_key_powers,
    output logic                                        o_key_ready
);

    typedef enum logic [1:0] {
        IDLE,
        BUILD,
        READY
    } key_state_t;

    key_state_t                                 state;
    // Index of the power feeding the next multiply
    logic [$clog2(ghash_pkg::N_LANES+1)-1:0]    src_idx;
    ghash_pkg::block_t                          next_power;

    // o_key_powers[j] holds H^(j+1)
    assign next_power = ghash_pkg::gf_reduce(
        ghash_pkg::clmul(o_key_powers[src_idx], o_key_powers[0]));

    assign o_key_ready = (state == READY);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state   <= IDLE;
            src_idx <= '0;
        end else if (i_key_load) begin
            src_idx <= '0;
            // A single lane needs no higher powers
            state   <= (ghash_pkg::N_LANES == 1) ? READY : BUILD;
        end else if (state == BUILD) begin
            src_idx <= src_idx + 1'b1;
            if (src_idx == ghash_pkg::N_LANES - 2) begin
                state <= READY;
            end
        end
    end

    // One higher power per cycle while building
    always_ff @(posedge i_clock) begin
        if (i_key_load) begin
            o_key_powers[0] <= i_hash_key;
        end else if (state == BUILD) begin
            o_key_powers[src_idx + 1'b1] <= next_power;
        end
    end

endmodule

//--- ghash_pkg.sv
package ghash_pkg;

    // GHASH block and grouping
    localparam int BLOCK_BITS = 128;
    localparam int N_LANES    = 2;
    localparam int FIFO_DEPTH = 4;

    typedef logic [BLOCK_BITS-1:0]         block_t;
    typedef logic [2*BLOCK_BITS-2:0]       product_t;
    // Block 0, the first in the message, sits in the low bits
    typedef logic [N_LANES*BLOCK_BITS-1:0] group_t;

    // Bit 127 is the x^0 coefficient, as in the GCM specification.
    // These are the low terms 1 + x + x^2 + x^7 of x^128 + x^7 + x^2 + x + 1
    localparam block_t GCM_POLY = 128'he100_0000_0000_0000_0000_0000_0000_0000;

    // Unreduced product. Coefficient of x^k lands at bit 254-k, so the
    // top 128 bits hold x^0..x^127 and the low 127 bits hold x^128..x^254
    function automatic product_t clmul(input block_t a, input block_t b);
        product_t acc;
        acc = '0;
        for (int i = 0; i < BLOCK_BITS; i++) begin
            // Coefficient of x^i in a
            if (a[BLOCK_BITS-1-i]) begin
                acc = acc ^ ({b, {(BLOCK_BITS-1){1'b0}}} >> i);
            end
        end
        return acc;
    endfunction

    // Clear overflow terms from the highest degree down
    function automatic block_t gf_reduce(input product_t p);
        product_t acc;
        product_t poly_ext;
        acc      = p;
        poly_ext = {GCM_POLY, {(BLOCK_BITS-1){1'b0}}};
        for (int i = 0; i < BLOCK_BITS-1; i++) begin
            // Bit i holds x^(254-i); replace x^128 * x^(126-i) by the low terms
            if (acc[i]) begin
                acc[i] = 1'b0;
                acc    = acc ^ (poly_ext >> (BLOCK_BITS-2-i));
            end
        end
        return acc[2*BLOCK_BITS-2 -: BLOCK_BITS];
    endfunction

endpackage
